// File: common/rv_core_pkg.sv
// shared types for the five-stage rv32i subset core
// only the opcodes listed in opcode_e are decoded, anything else runs as a bubble
// ctrl_t of all zeros is the pipeline bubble (add, no writes, no memory access)
`default_nettype none

package rv_core_pkg;

    typedef logic [31:0] word_t;        // data, address and instruction
    typedef logic [4:0]  reg_addr_t;    // register index

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,        // reg-reg alu
        OPC_OP_IMM = 7'b0010011,        // reg-imm alu
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,        // lw only
        OPC_STORE  = 7'b0100011,        // sw only
        OPC_BRANCH = 7'b1100011         // beq / bne
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD    = 3'd0,              // must stay zero, bubble default
        ALU_SUB    = 3'd1,
        ALU_AND    = 3'd2,
        ALU_OR     = 3'd3,
        ALU_XOR    = 3'd4,
        ALU_SLT    = 3'd5,
        ALU_PASS_B = 3'd6               // lui
    } alu_op_e;

    typedef enum logic [1:0] {
        FWD_NONE = 2'd0,                // register file / id-ex value
        FWD_MEM  = 2'd1,                // alu result sitting in mem stage
        FWD_WB   = 2'd2                 // final write-back data
    } fwd_sel_e;

    typedef struct packed {
        alu_op_e alu_op;
        logic    src_b_imm;             // alu b from immediate
        logic    reg_we;                // writes rd, never set for x0
        logic    mem_we;                // store
        logic    mem_to_reg;            // load
    } ctrl_t;

    localparam word_t NOP_INSTR = 32'h0000_0013;   // addi x0, x0, 0

    // operand bypass mux, used by decode compare and execute
    function automatic word_t fwd_mux(input fwd_sel_e sel, input word_t reg_val,
                                      input word_t mem_val, input word_t wb_val);
        case (sel)
            FWD_MEM: return mem_val;
            FWD_WB:  return wb_val;
            default: return reg_val;
        endcase
    endfunction

endpackage

`default_nettype wire

// File: common/hazard_if.sv
// stage <-> hazard unit bundle, purely combinational signals
// unused source addresses are driven as x0 so they never match
`default_nettype none

interface hazard_if;
    rv_core_pkg::reg_addr_t ra1_id, ra2_id, ra1_ex, ra2_ex;     // source regs
    rv_core_pkg::reg_addr_t wa_ex, wa_mem, wa_wb;               // destination regs
    logic                   branch_id;                          // branch sits in decode
    logic                   reg_we_ex, mem_to_reg_ex;
    logic                   reg_we_mem, mem_req_mem;
    logic                   reg_we_wb;
    logic                   stall_if, stall_id, stall_ex, stall_mem, flush_ex;
    rv_core_pkg::fwd_sel_e  fwd_a_ex, fwd_b_ex, fwd_a_id, fwd_b_id;

    modport hazard (
        input  ra1_id, ra2_id, branch_id, ra1_ex, ra2_ex, wa_ex, reg_we_ex, mem_to_reg_ex,
               wa_mem, reg_we_mem, mem_req_mem, wa_wb, reg_we_wb,
        output stall_if, stall_id, stall_ex, stall_mem, flush_ex,
               fwd_a_ex, fwd_b_ex, fwd_a_id, fwd_b_id
    );
    modport fetch   (input stall_if, stall_id);
    modport decode  (output ra1_id, ra2_id, branch_id, input stall_id, flush_ex, fwd_a_id, fwd_b_id);
    modport execute (output ra1_ex, ra2_ex, wa_ex, reg_we_ex, mem_to_reg_ex,
                     input stall_ex, fwd_a_ex, fwd_b_ex);
    modport memwb   (output wa_mem, reg_we_mem, mem_req_mem, wa_wb, reg_we_wb, input stall_mem);
endinterface

`default_nettype wire

// File: design/decode/reg_file.sv
// 32 x 32 register file, two read ports, one write port
// same-cycle write is bypassed to the reads, x0 reads zero
`default_nettype none

module reg_file (
    input  logic                   clk_i,
    input  rv_core_pkg::reg_addr_t ra1_i,
    input  rv_core_pkg::reg_addr_t ra2_i,
    output rv_core_pkg::word_t     rd1_o,
    output rv_core_pkg::word_t     rd2_o,
    input  rv_core_pkg::reg_addr_t wa_i,
    input  rv_core_pkg::word_t     wd_i,
    input  logic                   we_i
);
    rv_core_pkg::word_t regs [0:31];

    always_ff @(posedge clk_i) begin
        if (we_i)
            regs[wa_i] <= wd_i;
    end

    assign rd1_o = (ra1_i == '0) ? '0 : (we_i && wa_i == ra1_i) ? wd_i : regs[ra1_i];
    assign rd2_o = (ra2_i == '0) ? '0 : (we_i && wa_i == ra2_i) ? wd_i : regs[ra2_i];

endmodule

`default_nettype wire

// File: design/decode/instr_decoder.sv
// decode stage: control word, immediates, branch compare and target, id/ex register
// branches resolve here with forwarded operands; a stalled branch never redirects
// unsupported opcodes decode to a bubble
`default_nettype none

module instr_decoder (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    hazard_if.decode               hz,
    input  rv_core_pkg::word_t     instr_i,
    input  rv_core_pkg::word_t     pc_i,
    input  rv_core_pkg::reg_addr_t wb_addr_i,
    input  rv_core_pkg::word_t     wb_data_i,
    input  logic                   wb_we_i,
    input  rv_core_pkg::word_t     mem_result_i,
    output logic                   branch_taken_o,
    output rv_core_pkg::word_t     branch_target_o,
    output rv_core_pkg::ctrl_t     ctrl_o,
    output rv_core_pkg::word_t     op_a_o,
    output rv_core_pkg::word_t     op_b_o,
    output rv_core_pkg::word_t     imm_o,
    output rv_core_pkg::reg_addr_t rs1_o,
    output rv_core_pkg::reg_addr_t rs2_o,
    output rv_core_pkg::reg_addr_t rd_o
);
    rv_core_pkg::ctrl_t     ctrl;
    rv_core_pkg::word_t     imm;
    rv_core_pkg::word_t     rd1, rd2;       // raw register file reads
    rv_core_pkg::word_t     cmp_a, cmp_b;   // bypassed, compare only
    rv_core_pkg::reg_addr_t rd;
    logic                   use_rs1, use_rs2, is_branch;

    function automatic rv_core_pkg::alu_op_e alu_sel(input logic [2:0] funct3, input logic sub);
        case (funct3)
            3'b000:  return sub ? rv_core_pkg::ALU_SUB : rv_core_pkg::ALU_ADD;
            3'b010:  return rv_core_pkg::ALU_SLT;
            3'b100:  return rv_core_pkg::ALU_XOR;
            3'b110:  return rv_core_pkg::ALU_OR;
            3'b111:  return rv_core_pkg::ALU_AND;
            default: return rv_core_pkg::ALU_ADD;   // shifts not supported
        endcase
    endfunction

    assign rd           = instr_i[11:7];
    assign hz.ra1_id    = use_rs1 ? instr_i[19:15] : '0;    // x0 when unused, no false hazard
    assign hz.ra2_id    = use_rs2 ? instr_i[24:20] : '0;
    assign hz.branch_id = is_branch;

    reg_file u_reg_file (
        .clk_i(clk_i), .ra1_i(hz.ra1_id), .ra2_i(hz.ra2_id), .rd1_o(rd1), .rd2_o(rd2),
        .wa_i(wb_addr_i), .wd_i(wb_data_i), .we_i(wb_we_i)
    );

    always_comb begin
        ctrl      = '0;
        imm       = '0;
        use_rs1   = 1'b0;
        use_rs2   = 1'b0;
        is_branch = 1'b0;
        case (instr_i[6:0])
            rv_core_pkg::OPC_OP: begin
                ctrl.reg_we = 1'b1;
                ctrl.alu_op = alu_sel(instr_i[14:12], instr_i[30]);
                use_rs1     = 1'b1;
                use_rs2     = 1'b1;
            end
            rv_core_pkg::OPC_OP_IMM: begin
                ctrl.reg_we    = 1'b1;
                ctrl.src_b_imm = 1'b1;
                ctrl.alu_op    = alu_sel(instr_i[14:12], 1'b0);  // no subi
                use_rs1        = 1'b1;
                imm            = {{20{instr_i[31]}}, instr_i[31:20]};
            end
            rv_core_pkg::OPC_LUI: begin
                ctrl.reg_we    = 1'b1;
                ctrl.src_b_imm = 1'b1;
                ctrl.alu_op    = rv_core_pkg::ALU_PASS_B;
                imm            = {instr_i[31:12], 12'b0};
            end
            rv_core_pkg::OPC_LOAD: begin
                ctrl.reg_we     = 1'b1;
                ctrl.src_b_imm  = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                use_rs1         = 1'b1;
                imm             = {{20{instr_i[31]}}, instr_i[31:20]};
            end
            rv_core_pkg::OPC_STORE: begin
                ctrl.mem_we    = 1'b1;
                ctrl.src_b_imm = 1'b1;
                use_rs1        = 1'b1;
                use_rs2        = 1'b1;      // store data
                imm            = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
            end
            rv_core_pkg::OPC_BRANCH: begin
                is_branch = 1'b1;
                use_rs1   = 1'b1;
                use_rs2   = 1'b1;
                imm = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
            end
            default: ctrl = '0;
        endcase
        ctrl.reg_we = ctrl.reg_we && (rd != '0);    // nop and x0 targets write nothing
    end

    assign cmp_a           = rv_core_pkg::fwd_mux(hz.fwd_a_id, rd1, mem_result_i, wb_data_i);
    assign cmp_b           = rv_core_pkg::fwd_mux(hz.fwd_b_id, rd2, mem_result_i, wb_data_i);
    assign branch_target_o = pc_i + imm;
    // funct3[0] low is beq, high is bne
    assign branch_taken_o  = is_branch && !hz.stall_id && ((cmp_a == cmp_b) != instr_i[12]);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i)
            ctrl_o <= '0;
        else if (hz.flush_ex)
            ctrl_o <= '0;                   // bubble into execute
        else if (!hz.stall_id)
            ctrl_o <= ctrl;
    end

    always_ff @(posedge clk_i) begin
        if (!hz.stall_id) begin
            op_a_o <= rd1;                  // execute does its own bypass
            op_b_o <= rd2;
            imm_o  <= imm;
            rs1_o  <= hz.ra1_id;
            rs2_o  <= hz.ra2_id;
            rd_o   <= rd;
        end
    end

endmodule

`default_nettype wire

// File: design/fetch_stage.sv
// pc, instruction request and if/id register
// the request is held at a fixed pc until acked, the pc only moves on an accepted ack
`default_nettype none

module fetch_stage #(
    parameter rv_core_pkg::word_t RESET_PC = 32'h0000_0000
) (
    input  logic               clk_i,
    input  logic               arst_n_i,
    hazard_if.fetch            hz,
    output rv_core_pkg::word_t imem_addr_o,
    output logic               imem_req_o,
    input  logic               imem_ack_i,
    input  rv_core_pkg::word_t imem_rdata_i,
    input  logic               branch_taken_i,
    input  rv_core_pkg::word_t branch_target_i,
    output rv_core_pkg::word_t instr_o,
    output rv_core_pkg::word_t pc_o
);
    rv_core_pkg::word_t pc;
    rv_core_pkg::word_t hold_instr;         // copy of an instr acked during a decode stall
    logic               hold_valid;

    assign imem_req_o  = 1'b1;              // always fetching
    assign imem_addr_o = pc;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc         <= RESET_PC;
            hold_valid <= 1'b0;
            instr_o    <= rv_core_pkg::NOP_INSTR;
        end else begin
            if (branch_taken_i)
                pc <= branch_target_i;      // redirect, acked slot is dropped
            else if (!hz.stall_if)
                pc <= pc + 32'd4;           // stall_if low implies ack
            if (branch_taken_i || !hz.stall_id)
                hold_valid <= 1'b0;
            else if (imem_ack_i)
                hold_valid <= 1'b1;
            if (branch_taken_i)
                instr_o <= rv_core_pkg::NOP_INSTR;          // squashed slot
            else if (!hz.stall_id)
                instr_o <= hz.stall_if ? rv_core_pkg::NOP_INSTR :
                           (hold_valid ? hold_instr : imem_rdata_i);
        end
    end

    always_ff @(posedge clk_i) begin
        if (imem_ack_i && hz.stall_id && !hold_valid)
            hold_instr <= imem_rdata_i;     // first ack while decode waits
        if (!hz.stall_id)
            pc_o <= pc;
    end

endmodule

`default_nettype wire

// File: design/execute_stage.sv
// execute stage: operand bypass, alu and ex/mem register
// store data is the bypassed rs2 value, taken before the immediate mux
`default_nettype none

module execute_stage (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    hazard_if.execute              hz,
    input  rv_core_pkg::ctrl_t     ctrl_i,
    input  rv_core_pkg::word_t     op_a_i,
    input  rv_core_pkg::word_t     op_b_i,
    input  rv_core_pkg::word_t     imm_i,
    input  rv_core_pkg::reg_addr_t rs1_i,
    input  rv_core_pkg::reg_addr_t rs2_i,
    input  rv_core_pkg::reg_addr_t rd_i,
    input  rv_core_pkg::word_t     mem_result_i,
    input  rv_core_pkg::word_t     wb_data_i,
    output rv_core_pkg::ctrl_t     ctrl_o,
    output rv_core_pkg::word_t     result_o,
    output rv_core_pkg::word_t     store_data_o,
    output rv_core_pkg::reg_addr_t rd_o
);
    rv_core_pkg::word_t src_a;
    rv_core_pkg::word_t src_b_reg;          // bypassed rs2
    rv_core_pkg::word_t src_b;
    rv_core_pkg::word_t alu_res;

    assign hz.ra1_ex        = rs1_i;
    assign hz.ra2_ex        = rs2_i;
    assign hz.wa_ex         = rd_i;
    assign hz.reg_we_ex     = ctrl_i.reg_we;
    assign hz.mem_to_reg_ex = ctrl_i.mem_to_reg;  // load-use check

    assign src_a     = rv_core_pkg::fwd_mux(hz.fwd_a_ex, op_a_i, mem_result_i, wb_data_i);
    assign src_b_reg = rv_core_pkg::fwd_mux(hz.fwd_b_ex, op_b_i, mem_result_i, wb_data_i);
    assign src_b     = ctrl_i.src_b_imm ? imm_i : src_b_reg;

    always_comb begin
        case (ctrl_i.alu_op)
            rv_core_pkg::ALU_SUB:    alu_res = src_a - src_b;
            rv_core_pkg::ALU_AND:    alu_res = src_a & src_b;
            rv_core_pkg::ALU_OR:     alu_res = src_a | src_b;
            rv_core_pkg::ALU_XOR:    alu_res = src_a ^ src_b;
            rv_core_pkg::ALU_SLT:    alu_res = {31'b0, $signed(src_a) < $signed(src_b)};
            rv_core_pkg::ALU_PASS_B: alu_res = src_b;   // lui
            default:                 alu_res = src_a + src_b;   // add, lw/sw address
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i)
            ctrl_o <= '0;
        else if (!hz.stall_ex)
            ctrl_o <= ctrl_i;
    end

    always_ff @(posedge clk_i) begin
        if (!hz.stall_ex) begin
            result_o     <= alu_res;
            store_data_o <= src_b_reg;
            rd_o         <= rd_i;
        end
    end

endmodule

`default_nettype wire

// File: design/mem_wb_stage.sv
// memory and write-back: data request straight from ex/mem, mem/wb register
// mem/wb loads on the data ack, or every cycle when no access is pending
`default_nettype none

module mem_wb_stage (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    hazard_if.memwb                hz,
    input  rv_core_pkg::ctrl_t     ctrl_i,
    input  rv_core_pkg::word_t     result_i,
    input  rv_core_pkg::word_t     store_data_i,
    input  rv_core_pkg::reg_addr_t rd_i,
    output rv_core_pkg::word_t     dmem_addr_o,
    output rv_core_pkg::word_t     dmem_wdata_o,
    output logic                   dmem_we_o,
    output logic                   dmem_req_o,
    input  logic                   dmem_ack_i,
    input  rv_core_pkg::word_t     dmem_rdata_i,
    output rv_core_pkg::word_t     mem_result_o,
    output rv_core_pkg::reg_addr_t wb_addr_o,
    output rv_core_pkg::word_t     wb_data_o,
    output logic                   wb_we_o
);
    rv_core_pkg::word_t alu_wb;
    rv_core_pkg::word_t load_wb;
    logic               mem_to_reg_wb;

    assign dmem_req_o   = ctrl_i.mem_we || ctrl_i.mem_to_reg;
    assign dmem_we_o    = ctrl_i.mem_we;
    assign dmem_addr_o  = result_i;
    assign dmem_wdata_o = store_data_i;
    assign mem_result_o = result_i;         // bypass, alu results only

    assign hz.wa_mem      = rd_i;
    assign hz.reg_we_mem  = ctrl_i.reg_we;
    assign hz.mem_req_mem = dmem_req_o;     // with reg_we marks a load
    assign hz.wa_wb       = wb_addr_o;
    assign hz.reg_we_wb   = wb_we_o;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_we_o       <= 1'b0;
            mem_to_reg_wb <= 1'b0;
        end else if (!hz.stall_mem) begin   // hold while the data ack is missing
            wb_we_o       <= ctrl_i.reg_we;
            mem_to_reg_wb <= ctrl_i.mem_to_reg;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!hz.stall_mem) begin
            wb_addr_o <= rd_i;
            alu_wb    <= result_i;
            load_wb   <= dmem_rdata_i;      // valid only in the ack cycle
        end
    end

    assign wb_data_o = mem_to_reg_wb ? load_wb : alu_wb;

endmodule

`default_nettype wire

// File: design/hazard_unit.sv
// stall, flush and bypass select generation, purely combinational
// branches in decode also wait for the instruction ack so the fetch address stays stable
`default_nettype none

module hazard_unit (
    hazard_if.hazard hz,
    input  logic     imem_ack_i,
    input  logic     dmem_ack_i
);
    logic dep_ex;                           // decode reads the execute destination
    logic dep_mem_load;                     // decode reads a load still in mem
    logic load_use;
    logic branch_hold;
    logic dmem_wait;

    function automatic logic hit(input rv_core_pkg::reg_addr_t ra,
                                 input rv_core_pkg::reg_addr_t wa, input logic we);
        return we && (wa != '0) && (wa == ra);
    endfunction

    function automatic rv_core_pkg::fwd_sel_e src_sel(input rv_core_pkg::reg_addr_t ra);
        if (hit(ra, hz.wa_mem, hz.reg_we_mem))
            return rv_core_pkg::FWD_MEM;    // youngest producer first
        if (hit(ra, hz.wa_wb, hz.reg_we_wb))
            return rv_core_pkg::FWD_WB;
        return rv_core_pkg::FWD_NONE;
    endfunction

    always_comb begin
        hz.fwd_a_ex = src_sel(hz.ra1_ex);
        hz.fwd_b_ex = src_sel(hz.ra2_ex);
        hz.fwd_a_id = src_sel(hz.ra1_id);   // mem load case is stalled below
        hz.fwd_b_id = src_sel(hz.ra2_id);

        dep_ex       = hit(hz.ra1_id, hz.wa_ex, hz.reg_we_ex) ||
                       hit(hz.ra2_id, hz.wa_ex, hz.reg_we_ex);
        dep_mem_load = hz.mem_req_mem && (hit(hz.ra1_id, hz.wa_mem, hz.reg_we_mem) ||
                                          hit(hz.ra2_id, hz.wa_mem, hz.reg_we_mem));
        load_use     = hz.mem_to_reg_ex && dep_ex;
        branch_hold  = hz.branch_id && (dep_ex || dep_mem_load || !imem_ack_i);
        dmem_wait    = hz.mem_req_mem && !dmem_ack_i;   // freezes the whole pipe

        hz.stall_mem = dmem_wait;
        hz.stall_ex  = dmem_wait;
        hz.stall_id  = dmem_wait || load_use || branch_hold;
        hz.stall_if  = dmem_wait || load_use || branch_hold || !imem_ack_i;
        hz.flush_ex  = (load_use || branch_hold) && !dmem_wait;  // decode held, ex runs on
    end

endmodule

`default_nettype wire

// File: design/rv_core.sv
// five-stage in-order rv32i subset core (add sub and or xor slt, imm forms, lui, lw, sw, beq, bne)
// both memory ports use req/ack, req holds with stable address until ack, rdata valid on ack
// instruction memory is read-only, data accesses are full words
`default_nettype none

module rv_core #(
    parameter rv_core_pkg::word_t RESET_PC = 32'h0000_0000
) (
    input  logic               clk_i,
    input  logic               arst_n_i,
    output rv_core_pkg::word_t imem_addr_o,
    output logic               imem_req_o,
    input  logic               imem_ack_i,
    input  rv_core_pkg::word_t imem_rdata_i,
    output rv_core_pkg::word_t dmem_addr_o,
    output rv_core_pkg::word_t dmem_wdata_o,
    output logic               dmem_we_o,
    output logic               dmem_req_o,
    input  logic               dmem_ack_i,
    input  rv_core_pkg::word_t dmem_rdata_i
);
    rv_core_pkg::word_t     instr_id, pc_id, branch_target;     // if/id and redirect
    logic                   branch_taken;
    rv_core_pkg::ctrl_t     ctrl_ex, ctrl_mem;
    rv_core_pkg::word_t     op_a_ex, op_b_ex, imm_ex;           // id/ex payload
    rv_core_pkg::reg_addr_t rs1_ex, rs2_ex, rd_ex, rd_mem;
    rv_core_pkg::word_t     result_mem, store_data_mem;         // ex/mem payload
    rv_core_pkg::word_t     mem_result, wb_data;                // bypass sources
    rv_core_pkg::reg_addr_t wb_addr;
    logic                   wb_we;

    hazard_if hz ();

    fetch_stage #(.RESET_PC(RESET_PC)) u_fetch (
        .clk_i(clk_i), .arst_n_i(arst_n_i), .hz(hz.fetch),
        .imem_addr_o(imem_addr_o), .imem_req_o(imem_req_o),
        .imem_ack_i(imem_ack_i), .imem_rdata_i(imem_rdata_i),
        .branch_taken_i(branch_taken), .branch_target_i(branch_target),
        .instr_o(instr_id), .pc_o(pc_id)
    );

    instr_decoder u_decode (
        .clk_i(clk_i), .arst_n_i(arst_n_i), .hz(hz.decode),
        .instr_i(instr_id), .pc_i(pc_id),
        .wb_addr_i(wb_addr), .wb_data_i(wb_data), .wb_we_i(wb_we), .mem_result_i(mem_result),
        .branch_taken_o(branch_taken), .branch_target_o(branch_target),
        .ctrl_o(ctrl_ex), .op_a_o(op_a_ex), .op_b_o(op_b_ex), .imm_o(imm_ex),
        .rs1_o(rs1_ex), .rs2_o(rs2_ex), .rd_o(rd_ex)
    );

    execute_stage u_execute (
        .clk_i(clk_i), .arst_n_i(arst_n_i), .hz(hz.execute),
        .ctrl_i(ctrl_ex), .op_a_i(op_a_ex), .op_b_i(op_b_ex), .imm_i(imm_ex),
        .rs1_i(rs1_ex), .rs2_i(rs2_ex), .rd_i(rd_ex),
        .mem_result_i(mem_result), .wb_data_i(wb_data),
        .ctrl_o(ctrl_mem), .result_o(result_mem), .store_data_o(store_data_mem), .rd_o(rd_mem)
    );

    mem_wb_stage u_mem_wb (
        .clk_i(clk_i), .arst_n_i(arst_n_i), .hz(hz.memwb),
        .ctrl_i(ctrl_mem), .result_i(result_mem), .store_data_i(store_data_mem), .rd_i(rd_mem),
        .dmem_addr_o(dmem_addr_o), .dmem_wdata_o(dmem_wdata_o), .dmem_we_o(dmem_we_o),
        .dmem_req_o(dmem_req_o), .dmem_ack_i(dmem_ack_i), .dmem_rdata_i(dmem_rdata_i),
        .mem_result_o(mem_result), .wb_addr_o(wb_addr), .wb_data_o(wb_data), .wb_we_o(wb_we)
    );

    hazard_unit u_hazard (
        .hz(hz.hazard), .imem_ack_i(imem_ack_i), .dmem_ack_i(dmem_ack_i)
    );

endmodule

`default_nettype wire

// File: dv/tb_rv_core.sv
// drives rv_core with a fixed program from a rom function and a 64-word data memory model
// phase one jitters both acks by 0 to 3 cycles and phase two acks at once
// expected stores are hand-computed constants and the reset vector is 0x100
`default_nettype none

module tb_rv_core;
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] RESET_PC     = 32'h0000_0100;
    localparam logic [31:0] NOP          = 32'h0000_0013;   // addi x0, x0, 0
    localparam logic [6:0]  OPC_IMM      = 7'b0010011;
    localparam logic [6:0]  OPC_LOAD     = 7'b0000011;
    localparam logic [31:0] SKIPPED_ADDR = 32'h0000_00a0;   // store behind the taken beq
    localparam int          NUM_WRITES   = 7;
    localparam int          RUN_LIMIT    = 400;             // cycles per program run
    localparam int          QUIET_CYCLES = 20;

    logic        clk_i, arst_n_i;
    logic [31:0] imem_addr_o, imem_rdata_i;
    logic        imem_req_o, imem_ack_i;
    logic [31:0] dmem_addr_o, dmem_wdata_o, dmem_rdata_i;
    logic        dmem_we_o, dmem_req_o, dmem_ack_i;

    logic [31:0] dmem [0:63];
    logic [31:0] rng;                       // lcg state
    logic        jitter_on, rst_hold;
    int          imem_wait, dmem_wait;      // cycles left before the next ack
    int          n_writes, errors, timeouts;

    rv_core #(.RESET_PC(RESET_PC)) u_dut (
        .clk_i(clk_i), .arst_n_i(arst_n_i),
        .imem_addr_o(imem_addr_o), .imem_req_o(imem_req_o),
        .imem_ack_i(imem_ack_i), .imem_rdata_i(imem_rdata_i),
        .dmem_addr_o(dmem_addr_o), .dmem_wdata_o(dmem_wdata_o), .dmem_we_o(dmem_we_o),
        .dmem_req_o(dmem_req_o), .dmem_ack_i(dmem_ack_i), .dmem_rdata_i(dmem_rdata_i)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // rv32i encodings
    function automatic logic [31:0] reg_reg_op(input logic [6:0] f7, input logic [4:0] rs2,
                                               input logic [4:0] rs1, input logic [2:0] f3,
                                               input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] imm_form(input logic [11:0] imm, input logic [4:0] rs1,
                                             input logic [2:0] f3, input logic [4:0] rd,
                                             input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] sw_instr(input logic [11:0] imm, input logic [4:0] rs2,
                                             input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] branch_instr(input logic [12:0] imm, input logic [4:0] rs2,
                                                 input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] lui_instr(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, 7'b0110111};
    endfunction

    // instruction rom indexed by (pc - reset vector) / 4
    function automatic logic [31:0] program_word(input logic [31:0] idx);
        case (idx)
            0:  return imm_form(12'd5, 5'd1 - 5'd1, 3'b000, 5'd1, OPC_IMM);  // x1 = 5
            1:  return imm_form(12'd7, 5'd1, 3'b000, 5'd2, OPC_IMM);         // x2 = 12
            2:  return reg_reg_op(7'h00, 5'd2, 5'd1, 3'b000, 5'd3);          // x3 = 17
            3:  return sw_instr(12'h080, 5'd3, 5'd0);                        // store data via mem
            4:  return reg_reg_op(7'h20, 5'd3, 5'd1, 3'b000, 5'd4);          // x4 = -12
            5:  return reg_reg_op(7'h00, 5'd2, 5'd4, 3'b100, 5'd5);          // x5 = -8
            6:  return reg_reg_op(7'h00, 5'd1, 5'd5, 3'b010, 5'd6);          // signed slt gives 1
            7:  return sw_instr(12'h084, 5'd5, 5'd0);
            8:  return sw_instr(12'h088, 5'd6, 5'd0);
            9:  return lui_instr(20'h12345, 5'd7);
            10: return imm_form(12'h678, 5'd7, 3'b110, 5'd7, OPC_IMM);       // ori
            11: return imm_form(12'h0f0, 5'd7, 3'b111, 5'd8, OPC_IMM);       // andi gives 0x70
            12: return reg_reg_op(7'h00, 5'd1, 5'd8, 3'b110, 5'd9);          // or gives 0x75
            13: return sw_instr(12'h08c, 5'd9, 5'd0);
            14: return sw_instr(12'h090, 5'd7, 5'd0);
            15: return imm_form(12'h040, 5'd0, 3'b010, 5'd10, OPC_LOAD);     // lw x10
            16: return reg_reg_op(7'h00, 5'd1, 5'd10, 3'b000, 5'd11);        // load-use
            17: return sw_instr(12'h094, 5'd11, 5'd0);
            18: return imm_form(12'd17, 5'd0, 3'b000, 5'd12, OPC_IMM);       // x12 = 17
            19: return branch_instr(13'd8, 5'd3, 5'd12, 3'b000);             // beq taken
            20: return sw_instr(SKIPPED_ADDR[11:0], 5'd1, 5'd0);             // never runs
            21: return branch_instr(13'd8, 5'd3, 5'd12, 3'b001);             // bne not taken
            22: return sw_instr(12'h098, 5'd12, 5'd0);
            23: return branch_instr(13'd0, 5'd0, 5'd0, 3'b000);              // self-loop
            default: return NOP;
        endcase
    endfunction

    // {address, data} of the n-th acknowledged store
    function automatic logic [63:0] expected_write(input int idx);
        case (idx)
            0: return {32'h0000_0080, 32'h0000_0011};
            1: return {32'h0000_0084, 32'hffff_fff8};
            2: return {32'h0000_0088, 32'h0000_0001};
            3: return {32'h0000_008c, 32'h0000_0075};
            4: return {32'h0000_0090, 32'h1234_5678};
            5: return {32'h0000_0094, 32'h5a00_0045};   // preload of 0x40 plus 5
            default: return {32'h0000_0098, 32'h0000_0011};
        endcase
    endfunction

    task automatic flag_error(input string msg);
        errors++;
        $display("** Error at %0d ns: %s", $time, msg);
    endtask

    task automatic pick_delay(output int cycles);
        rng    = lcg_next(rng);
        cycles = jitter_on ? int'(rng[17:16]) : 0;
    endtask

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    // reset and both memory responders driven 10 ns after the rising edge
    always @(posedge clk_i) begin
        #10;
        arst_n_i     = !rst_hold;
        imem_ack_i   = 1'b0;
        imem_rdata_i = 32'hbad0_0001;       // junk outside the ack cycle
        dmem_ack_i   = 1'b0;
        dmem_rdata_i = 32'hbad0_0002;
        if (imem_req_o && imem_wait == 0) begin
            imem_ack_i   = 1'b1;
            imem_rdata_i = program_word((imem_addr_o - RESET_PC) >> 2);
            pick_delay(imem_wait);          // delay of the next fetch
        end else if (imem_req_o) begin
            imem_wait--;
        end
        if (dmem_req_o && dmem_wait == 0) begin
            dmem_ack_i   = 1'b1;
            dmem_rdata_i = dmem[dmem_addr_o[7:2]];
            pick_delay(dmem_wait);
        end else if (dmem_req_o) begin
            dmem_wait--;
        end
    end

    // write log checked entry by entry against the expected order
    always @(negedge clk_i) begin : store_monitor
        logic [63:0] exp_wr;
        if (arst_n_i === 1'b1 && dmem_req_o && dmem_ack_i && dmem_we_o) begin
            assert (dmem_addr_o != SKIPPED_ADDR)
                else flag_error("store behind the taken branch was executed");
            assert (n_writes < NUM_WRITES)
                else flag_error($sformatf("extra store to %h", dmem_addr_o));
            if (n_writes < NUM_WRITES) begin
                exp_wr = expected_write(n_writes);
                assert (dmem_addr_o == exp_wr[63:32] && dmem_wdata_o == exp_wr[31:0])
                    else flag_error($sformatf("store %0d got %h <= %h, expected %h <= %h",
                                              n_writes, dmem_addr_o, dmem_wdata_o,
                                              exp_wr[63:32], exp_wr[31:0]));
            end
            dmem[dmem_addr_o[7:2]] = dmem_wdata_o;
            n_writes++;
        end
    end

    // a waiting request keeps its address, data and direction
    assert property (@(negedge clk_i) disable iff (arst_n_i !== 1'b1)
            (dmem_req_o && !dmem_ack_i) |=> (dmem_req_o && $stable(dmem_addr_o) &&
                                             $stable(dmem_wdata_o) && $stable(dmem_we_o)))
        else flag_error("data request changed before its acknowledge");

    assert property (@(negedge clk_i) disable iff (arst_n_i !== 1'b1)
            (imem_req_o && !imem_ack_i) |=> (imem_req_o && $stable(imem_addr_o)))
        else flag_error("fetch address changed before its acknowledge");

    task automatic run_program(input logic jitter);
        int cycles;
        @(negedge clk_i);
        rst_hold = 1'b1;                    // applied at the next drive point
        @(negedge clk_i);
        jitter_on = jitter;
        imem_wait = 0;
        dmem_wait = 0;
        n_writes  = 0;
        for (int i = 0; i < 64; i++)
            dmem[i] = 32'h5a00_0000 | (i << 2);     // tag plus byte address
        repeat (4) @(negedge clk_i);
        rst_hold = 1'b0;
        @(negedge clk_i);                   // first cycle out of reset
        assert (imem_addr_o == RESET_PC)
            else flag_error($sformatf("fetch address %h after reset", imem_addr_o));
        assert (imem_req_o && !dmem_req_o && !dmem_we_o)
            else flag_error("request lines wrong after reset");
        cycles = 0;
        while (n_writes < NUM_WRITES && cycles < RUN_LIMIT) begin
            @(posedge clk_i);
            cycles++;
        end
        if (n_writes < NUM_WRITES) begin
            timeouts++;
            $display("Timeout: only %0d of %0d stores seen after %0d cycles",
                     n_writes, NUM_WRITES, RUN_LIMIT);
        end else begin
            repeat (QUIET_CYCLES) begin
                @(negedge clk_i);
                assert (!dmem_req_o)
                    else flag_error("data request after the program reached its end loop");
            end
        end
    endtask

    initial begin
        arst_n_i     = 1'b0;
        rst_hold     = 1'b1;
        imem_ack_i   = 1'b0;
        imem_rdata_i = NOP;
        dmem_ack_i   = 1'b0;
        dmem_rdata_i = '0;
        rng          = 32'hfb59;
        jitter_on    = 1'b0;
        imem_wait    = 0;
        dmem_wait    = 0;
        n_writes     = 0;
        errors       = 0;
        timeouts     = 0;
        run_program(1'b1);                  // random ack delays
        run_program(1'b0);                  // acks in the request cycle
        $display("Summary: %0d errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: rv_core.f
common/rv_core_pkg.sv
common/hazard_if.sv
design/decode/reg_file.sv
design/decode/instr_decoder.sv
design/fetch_stage.sv
design/execute_stage.sv
design/mem_wb_stage.sv
design/hazard_unit.sv
design/rv_core.sv
dv/tb_rv_core.sv

// File: Bender.yml
package:
  name: rv_core

dependencies: {}

sources:
  - common/rv_core_pkg.sv
  - common/hazard_if.sv
  - design/decode/reg_file.sv
  - design/decode/instr_decoder.sv
  - design/fetch_stage.sv
  - design/execute_stage.sv
  - design/mem_wb_stage.sv
  - design/hazard_unit.sv
  - design/rv_core.sv
  - target: test
    files:
      - dv/tb_rv_core.sv
